// File: compile.f
+incdir+design
design/ic_pkg.sv
design/ic_sram.sv
design/ic_tag_array.sv
design/ic_data_array.sv
design/ic_way_mux.sv
design/ic_mem.sv
verif/ic_mem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ic_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f compile.f \
   --top-module ic_mem_tb \
   -Mdir obj_dir \
   -o ic_mem_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/ic_mem_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation passed"; then
   exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: verif/ic_mem_tb.sv
`default_nettype none

`include "ic_mem_macros.svh"

module ic_mem_tb;

   import ic_pkg::*;

   localparam int MAX_CYCLES    = 5000;

   logic                            clk = 1'b0;
   logic                            arst_n;
   ic_req_t                         req;
   logic [`IC_FILL_W-1:0]           fill_data;
   ic_dbg_t                         dbg;
   logic [`IC_NUM_WAYS-1:0]         tag_valid;
   logic [`IC_PREMUX_W-1:0]         premux_data;
   logic                            sel_premux;
   ic_tag_rsp_t                     tag_rsp;
   logic [`IC_ROW_W-1:0]            rd_data;
   logic [`IC_TAG_ENTRY_W-1:0]      dbg_tag_rd_data;

   // Reference model of both arrays
   logic [`IC_TAG_ENTRY_W-1:0]      m_tag [`IC_NUM_WAYS][`IC_TAG_DEPTH];
   logic [`IC_ROW_W-1:0]            m_row [`IC_NUM_WAYS][`IC_DATA_DEPTH];

   logic                            chk_en;      // Response cycle of a read
   logic [`IC_NUM_WAYS-1:0]         exp_hit;
   logic                            exp_perr;
   logic [`IC_ROW_W-1:0]            exp_data;
   logic [`IC_TAG_ENTRY_W-1:0]      exp_dbg;     // Zero unless a debug read is due

   logic                            prev_rd;     // Request of the last cycle
   logic [`IC_ADDR_W-1:3]           prev_addr;
   logic                            prev_drd;
   logic [`IC_NUM_WAYS-1:0]         prev_dway;
   logic [5:0]                      prev_didx;

   logic [31:0]                     rng = 32'd60057;

   ic_mem u_ic_mem (
      .clk             (clk),
      .arst_n          (arst_n),
      .req             (req),
      .fill_data       (fill_data),
      .dbg             (dbg),
      .tag_valid       (tag_valid),
      .premux_data     (premux_data),
      .sel_premux      (sel_premux),
      .tag_rsp         (tag_rsp),
      .rd_data         (rd_data),
      .dbg_tag_rd_data (dbg_tag_rd_data)
   );

   always #10 clk = ~clk;

   //////////////////////////////////////////////////
   // Failure reporting and random numbers
   //////////////////////////////////////////////////
   task automatic stop_fail(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "testbench stopped");
   endtask

   task automatic value_error(input string name, input logic [135:0] exp, input logic [135:0] got);
      stop_fail($sformatf("ERR %s expected 0x%0h got 0x%0h", name, exp, got));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////
   task automatic predict_read(input logic [31:3] a, input logic [3:0] tv, input logic sp,
                               input logic [127:0] pm);
      logic [20:0] ent;
      exp_hit  = '0;
      exp_perr = 1'b0;
      exp_data = '0;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         ent = m_tag[w][a[11:6]];
         if (tv[w] && ent[19:0] == a[31:12]) begin
            exp_hit[w] = 1'b1;
            exp_data  |= m_row[w][a[11:4]];
         end
         if (tv[w] && (^ent)) begin
            exp_perr = 1'b1;                     // Stored entry has odd parity
         end
      end
      if (sp) begin
         for (int k = 0; k < 4; k++) begin
            exp_data[k*34 +: 34] = {2'b00, pm[k*32 +: 32]};
         end
      end
   endtask

   function automatic logic [20:0] dbg_expect(input logic [3:0] way, input logic [5:0] idx);
      logic [20:0] ent;
      ent = '0;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         if (way[w]) begin
            ent |= m_tag[w][idx];
         end
      end
      return ent;
   endfunction

   task automatic update_model(input ic_req_t r, input logic [67:0] fd, input ic_dbg_t d);
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         if (r.wr_en[w]) begin
            if (r.addr[3]) begin
               m_row[w][r.addr[11:4]][135:68] = fd;
            end else begin
               m_row[w][r.addr[11:4]][67:0] = fd;
            end
            if (r.addr[5:3] == 3'b111) begin     // Last beat carries the tag
               m_tag[w][r.addr[11:6]] = {^r.addr[31:12], r.addr[31:12]};
            end
         end
         if (d.wr_en && d.way[w]) begin
            m_tag[w][d.index] = d.wr_data;
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   // tv, sp and pm answer the read of the previous cycle
   task automatic drive_cycle(input ic_req_t r, input logic [67:0] fd, input ic_dbg_t d,
                              input logic [3:0] tv, input logic sp, input logic [127:0] pm);
      @(posedge clk);
      #2;
      tag_valid   = tv;
      sel_premux  = sp;
      premux_data = pm;
      chk_en      = prev_rd;
      if (prev_rd) begin
         predict_read(prev_addr, tv, sp, pm);
      end
      exp_dbg = prev_drd ? dbg_expect(prev_dway, prev_didx) : '0;
      req       = r;
      fill_data = fd;
      dbg       = d;
      update_model(r, fd, d);
      prev_rd   = r.rd_en;
      prev_addr = r.addr;
      prev_drd  = d.rd_en;
      prev_dway = d.way;
      prev_didx = d.index;
   endtask

   task automatic idle_cycle(input logic [3:0] tv, input logic sp, input logic [127:0] pm);
      drive_cycle('0, '0, '0, tv, sp, pm);
   endtask

   function automatic ic_req_t read_req(input logic [31:3] a);
      ic_req_t r;
      r       = '0;
      r.rd_en = 1'b1;
      r.addr  = a;
      return r;
   endfunction

   task automatic fill_line(input logic [3:0] ways, input logic [19:0] tag, input logic [5:0] idx);
      ic_req_t     r;
      logic [31:0] lo;
      logic [31:0] hi;
      logic [31:0] par;
      for (int b = 0; b < 8; b++) begin
         lo     = next_rand();
         hi     = next_rand();
         par    = next_rand();
         r      = '0;
         r.wr_en = ways;
         r.addr = {tag, idx, 3'(b)};
         drive_cycle(r, {par[3:0], hi, lo}, '0, '0, 1'b0, '0);
      end
   endtask

   task automatic read_check(input logic [31:3] a, input logic [3:0] tv, input logic sp,
                             input logic [127:0] pm);
      drive_cycle(read_req(a), '0, '0, '0, 1'b0, '0);
      idle_cycle(tv, sp, pm);
   endtask

   task automatic dbg_access(input logic rd, input logic [3:0] way, input logic [5:0] idx,
                             input logic [20:0] ent);
      ic_dbg_t d;
      d         = '0;
      d.rd_en   = rd;
      d.wr_en   = ~rd;
      d.way     = way;
      d.index   = idx;
      d.wr_data = ent;
      drive_cycle('0, '0, d, '0, 1'b0, '0);
   endtask

   //////////////////////////////////////////////////
   // Checks, one cycle after each request
   //////////////////////////////////////////////////
   a_rd_hit : assert property (
      @(posedge clk) disable iff (!arst_n) chk_en |-> (tag_rsp.rd_hit == exp_hit)
   ) else value_error("tag_rsp.rd_hit", 136'($sampled(exp_hit)), 136'($sampled(tag_rsp.rd_hit)));

   a_tag_perr : assert property (
      @(posedge clk) disable iff (!arst_n) chk_en |-> (tag_rsp.tag_perr == exp_perr)
   ) else value_error("tag_rsp.tag_perr", 136'($sampled(exp_perr)),
                      136'($sampled(tag_rsp.tag_perr)));

   a_rd_data : assert property (
      @(posedge clk) disable iff (!arst_n) chk_en |-> (rd_data == exp_data)
   ) else value_error("rd_data", $sampled(exp_data), $sampled(rd_data));

   a_dbg_rd : assert property (
      @(posedge clk) disable iff (!arst_n) dbg_tag_rd_data == exp_dbg
   ) else value_error("dbg_tag_rd_data", 136'($sampled(exp_dbg)),
                      136'($sampled(dbg_tag_rd_data)));

   initial begin
      for (int c = 0; c < MAX_CYCLES; c++) begin
         @(posedge clk);
      end
      stop_fail($sformatf("Watchdog expired after %0d cycles", MAX_CYCLES));
   end

   initial begin
      logic [31:0]  r;
      logic [19:0]  base;
      logic [5:0]   idx1;
      logic [5:0]   idx3;
      logic [3:0]   w1;
      logic [19:0]  t5;
      logic [127:0] pm;
      arst_n = 1'b0;
      req = '0;
      fill_data = '0;
      dbg = '0;
      tag_valid = '0;
      premux_data = '0;
      sel_premux = 1'b0;
      chk_en = 1'b0;
      exp_hit = '0;
      exp_perr = 1'b0;
      exp_data = '0;
      exp_dbg = '0;
      prev_rd = 1'b0;
      prev_addr = '0;
      prev_drd = 1'b0;
      prev_dway = '0;
      prev_didx = '0;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         for (int i = 0; i < `IC_TAG_DEPTH; i++) begin
            m_tag[w][i] = '0;
         end
         for (int i = 0; i < `IC_DATA_DEPTH; i++) begin
            m_row[w][i] = '0;
         end
      end
      repeat (4) @(posedge clk);
      #2;
      arst_n = 1'b1;

      // Known tags everywhere, all ones with even parity
      for (int i = 0; i < `IC_TAG_DEPTH; i++) begin
         dbg_access(1'b0, 4'hF, 6'(i), 21'h0FFFFF);
      end

      r    = next_rand();
      base = {1'b0, r[18:3], 3'b000};               // Test tags never reach all ones
      idx1 = r[25:20];
      idx3 = idx1 ^ 6'h01;
      w1   = 4'b0001 << r[31:30];

      // Whole line in one way, then every row
      fill_line(w1, base, idx1);
      for (int k = 0; k < 4; k++) begin
         read_check({base, idx1, 2'(k), 1'b0}, 4'hF, 1'b0, '0);
      end

      // Misses, by tag and by valid
      read_check({base | 20'd1, idx1, 3'b000}, 4'hF, 1'b0, '0);
      read_check({base, idx1, 3'b010}, ~w1, 1'b0, '0);

      // Four ways at one index
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         fill_line(4'b0001 << w, base | 20'(4 + w), idx3);
      end
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         read_check({base | 20'(4 + w), idx3, 2'(w), 1'b1}, 4'hF, 1'b0, '0);
      end

      // Premux bypass on a hit and on a miss
      pm = {next_rand(), next_rand(), next_rand(), next_rand()};
      read_check({base | 20'd5, idx3, 3'b000}, 4'hF, 1'b1, pm);
      read_check({base | 20'd1, idx1, 3'b000}, 4'hF, 1'b1, pm);

      // Bad parity in way 2
      t5 = base | 20'd2;
      dbg_access(1'b0, 4'b0100, idx3, {~(^t5), t5});
      read_check({t5, idx3, 3'b100}, 4'hF, 1'b0, '0);
      read_check({t5, idx3, 3'b100}, 4'b1011, 1'b0, '0);
      dbg_access(1'b1, 4'b0100, idx3, '0);
      dbg_access(1'b1, 4'b0001, idx1, '0);
      idle_cycle('0, 1'b0, '0);

      // Back-to-back reads, two in flight
      drive_cycle(read_req({base | 20'd4, idx3, 3'b000}), '0, '0, '0, 1'b0, '0);
      drive_cycle(read_req({base | 20'd5, idx3, 3'b010}), '0, '0, 4'hF, 1'b0, '0);
      drive_cycle(read_req({base, idx1, 3'b110}), '0, '0, 4'hF, 1'b0, '0);
      drive_cycle(read_req({base | 20'd7, idx3, 3'b100}), '0, '0, 4'hF, 1'b0, '0);
      idle_cycle(4'hF, 1'b0, '0);
      idle_cycle('0, 1'b0, '0);

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: design/ic_mem.sv
`default_nettype none

`include "ic_mem_macros.svh"

module ic_mem (
   input  wire logic                          clk,
   input  wire logic                          arst_n,
   input  wire ic_pkg::ic_req_t               req,
   input  wire logic [`IC_FILL_W-1:0]         fill_data,
   input  wire ic_pkg::ic_dbg_t               dbg,
   input  wire logic [`IC_NUM_WAYS-1:0]       tag_valid,     // Cycle after the read
   input  wire logic [`IC_PREMUX_W-1:0]       premux_data,
   input  wire logic                          sel_premux,    // Same cycle as tag_valid
   output ic_pkg::ic_tag_rsp_t                tag_rsp,
   output logic      [`IC_ROW_W-1:0]          rd_data,
   output logic      [`IC_TAG_ENTRY_W-1:0]    dbg_tag_rd_data
);

   logic [`IC_NUM_WAYS-1:0][`IC_ROW_W-1:0]    way_rows;

   //////////////////////////////////////////////////
   // Tag and data looked up in parallel
   //////////////////////////////////////////////////
   ic_tag_array u_tag_array (
      .clk         (clk),
      .arst_n      (arst_n),
      .req         (req),
      .dbg         (dbg),
      .tag_valid   (tag_valid),
      .tag_rsp     (tag_rsp),
      .dbg_rd_data (dbg_tag_rd_data)
   );

   ic_data_array u_data_array (
      .clk       (clk),
      .req       (req),
      .fill_data (fill_data),
      .way_rows  (way_rows)
   );

   //////////////////////////////////////////////////
   // Way select, same cycle as the RAM outputs
   //////////////////////////////////////////////////
   ic_way_mux u_way_mux (
      .tag_rsp     (tag_rsp),
      .way_rows    (way_rows),
      .sel_premux  (sel_premux),
      .premux_data (premux_data),
      .rd_data     (rd_data)
   );

endmodule

`default_nettype wire

// File: design/ic_way_mux.sv
`default_nettype none

`include "ic_mem_macros.svh"

module ic_way_mux (
   input  wire ic_pkg::ic_tag_rsp_t                      tag_rsp,
   input  wire logic [`IC_NUM_WAYS-1:0][`IC_ROW_W-1:0]   way_rows,
   input  wire logic                                     sel_premux,
   input  wire logic [`IC_PREMUX_W-1:0]                  premux_data,
   output logic      [`IC_ROW_W-1:0]                     rd_data
);

   localparam int PAR_W = `IC_BANK_W - `IC_WORD_W;

   logic [`IC_ROW_W-1:0] premux_ext;
   logic [`IC_ROW_W-1:0] hit_row;

   //////////////////////////////////////////////////
   // Premux widening, zero parity per word
   //////////////////////////////////////////////////
   for (genvar k = 0; k < `IC_NUM_BANKS; k++) begin : g_ext
      assign premux_ext[k * `IC_BANK_W +: `IC_BANK_W] =
         {{PAR_W{1'b0}}, premux_data[k * `IC_WORD_W +: `IC_WORD_W]};
   end

   // AND-OR select, all zero on a miss
   always_comb begin
      hit_row = '0;
      for (int i = 0; i < `IC_NUM_WAYS; i++) begin
         hit_row |= way_rows[i] & {`IC_ROW_W{tag_rsp.rd_hit[i]}};
      end
   end

   assign rd_data = sel_premux ? premux_ext : hit_row;

   // The AND-OR select is only valid with a single hitting way
   always_comb begin
      a_hit_onehot : assert final (
         sel_premux || $isunknown(tag_rsp.rd_hit) || $onehot0(tag_rsp.rd_hit)
      ) else $error("multiple way hit %b", tag_rsp.rd_hit);
   end

endmodule

`default_nettype wire

// File: design/ic_data_array.sv
`default_nettype none

`include "ic_mem_macros.svh"

module ic_data_array (
   input  wire logic                                 clk,
   input  wire ic_pkg::ic_req_t                      req,
   input  wire logic [`IC_FILL_W-1:0]                fill_data,
   output logic      [`IC_NUM_WAYS-1:0][`IC_ROW_W-1:0] way_rows
);

   localparam int ROW_IDX_W = `IC_TAG_HIGH - `IC_ROW_LOW;
   localparam int PAIR      = `IC_NUM_BANKS / 2;         // Banks per fill beat

   logic [ROW_IDX_W-1:0]                             row_index;
   logic                                             upper_pair;
   logic [`IC_NUM_WAYS-1:0][`IC_NUM_BANKS-1:0]       bank_we;   // Way, bank
   logic [`IC_NUM_BANKS-1:0][`IC_BANK_W-1:0]         bank_wr_data;

   assign row_index  = req.addr[`IC_TAG_HIGH-1:`IC_ROW_LOW];
   assign upper_pair = req.addr[3];                      // Second 8 bytes of the row

   //////////////////////////////////////////////////
   // Fill steering
   //////////////////////////////////////////////////
   for (genvar k = 0; k < `IC_NUM_BANKS; k++) begin : g_steer
      // Low half of the beat goes to the lower bank of the pair
      assign bank_wr_data[k] = fill_data[(k % PAIR) * `IC_BANK_W +: `IC_BANK_W];

      for (genvar i = 0; i < `IC_NUM_WAYS; i++) begin : g_we
         assign bank_we[i][k] = req.wr_en[i] & (upper_pair == (k >= PAIR));
      end
   end

   //////////////////////////////////////////////////
   // Storage, one RAM per way and bank
   //////////////////////////////////////////////////
   for (genvar i = 0; i < `IC_NUM_WAYS; i++) begin : g_way
      for (genvar k = 0; k < `IC_NUM_BANKS; k++) begin : g_bank
         ic_sram #(
            .width (`IC_BANK_W),
            .depth (`IC_DATA_DEPTH)
         ) u_data_ram (
            .clk  (clk),
            .we   (bank_we[i][k]),
            .addr (row_index),
            .d    (bank_wr_data[k]),
            .q    (way_rows[i][k * `IC_BANK_W +: `IC_BANK_W])   // Bank 0 lowest
         );
      end
   end

   // A fill must carry a clean address or RAM rows get corrupted
   a_fill_addr_known : assert property (
      @(posedge clk) (|req.wr_en) |-> !$isunknown(req.addr)
   ) else $error("fill with unknown address %h", req.addr);

endmodule

`default_nettype wire

// File: design/ic_tag_array.sv
`default_nettype none

`include "ic_mem_macros.svh"

module ic_tag_array (
   input  wire logic                              clk,
   input  wire logic                              arst_n,
   input  wire ic_pkg::ic_req_t                   req,
   input  wire ic_pkg::ic_dbg_t                   dbg,
   input  wire logic [`IC_NUM_WAYS-1:0]           tag_valid,  // Cycle after the read
   output ic_pkg::ic_tag_rsp_t                    tag_rsp,
   output logic      [`IC_TAG_ENTRY_W-1:0]        dbg_rd_data
);

   localparam int IDX_W = `IC_TAG_HIGH - `IC_TAG_LOW;

   logic [`IC_TAG_W-1:0]                          addr_tag;
   logic [`IC_TAG_W-1:0]                          addr_tag_ff;
   logic                                          tag_parity;
   logic                                          dbg_active;
   logic                                          last_beat;
   logic [IDX_W-1:0]                              tag_index;
   logic [`IC_TAG_ENTRY_W-1:0]                    tag_wr_data;
   logic [`IC_NUM_WAYS-1:0]                       tag_we;
   logic [`IC_NUM_WAYS-1:0]                       dbg_rd_way_en;
   logic [`IC_NUM_WAYS-1:0]                       dbg_wr_way_en;
   logic [`IC_NUM_WAYS-1:0]                       dbg_rd_way_ff;
   logic [`IC_NUM_WAYS-1:0][`IC_TAG_ENTRY_W-1:0]  tag_q;
   logic [`IC_NUM_WAYS-1:0]                       way_perr;
   logic [`IC_NUM_WAYS-1:0]                       way_match;

   //////////////////////////////////////////////////
   // Write path
   //////////////////////////////////////////////////
   assign addr_tag   = req.addr[`IC_ADDR_W-1:`IC_TAG_HIGH];
   assign tag_parity = ^addr_tag;                        // Even parity
   assign last_beat  = &req.addr[`IC_TAG_LOW-1:3];       // Beat 7 of the line

   assign dbg_active    = dbg.rd_en | dbg.wr_en;
   assign dbg_rd_way_en = {`IC_NUM_WAYS{dbg.rd_en}} & dbg.way;
   assign dbg_wr_way_en = {`IC_NUM_WAYS{dbg.wr_en}} & dbg.way;

   // Debug owns the index while it is active
   assign tag_index = dbg_active ? dbg.index
                                 : req.addr[`IC_TAG_HIGH-1:`IC_TAG_LOW];

   assign tag_wr_data = dbg.wr_en ? dbg.wr_data : {tag_parity, addr_tag};

   assign tag_we = (req.wr_en & {`IC_NUM_WAYS{last_beat}}) | dbg_wr_way_en;

   //////////////////////////////////////////////////
   // Second cycle state
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         addr_tag_ff   <= '0;
         dbg_rd_way_ff <= '0;
      end else begin
         if (req.rd_en) begin
            addr_tag_ff <= addr_tag;                     // Held until the next read
         end
         dbg_rd_way_ff <= dbg_rd_way_en;                 // Zero when no debug read
      end
   end

   //////////////////////////////////////////////////
   // Per-way storage and check
   //////////////////////////////////////////////////
   for (genvar i = 0; i < `IC_NUM_WAYS; i++) begin : g_way
      ic_sram #(
         .width (`IC_TAG_ENTRY_W),
         .depth (`IC_TAG_DEPTH)
      ) u_tag_ram (
         .clk  (clk),
         .we   (tag_we[i]),
         .addr (tag_index),
         .d    (tag_wr_data),
         .q    (tag_q[i])
      );

      assign way_perr[i]  = ^tag_q[i];                   // Odd count means a flipped bit
      assign way_match[i] = (tag_q[i][`IC_TAG_W-1:0] == addr_tag_ff);
   end

   assign tag_rsp.rd_hit   = way_match & tag_valid;
   assign tag_rsp.tag_perr = |(way_perr & tag_valid);

   // OR of the ways picked by the registered debug way
   always_comb begin
      dbg_rd_data = '0;
      for (int i = 0; i < `IC_NUM_WAYS; i++) begin
         dbg_rd_data |= tag_q[i] & {`IC_TAG_ENTRY_W{dbg_rd_way_ff[i]}};
      end
   end

   // Debug port serves one direction per cycle
   a_dbg_rd_wr_excl : assert property (
      @(posedge clk) disable iff (!arst_n) !(dbg.rd_en && dbg.wr_en)
   ) else $error("debug read and write requested together");

endmodule

`default_nettype wire

// File: design/ic_sram.sv
`default_nettype none

module ic_sram #(
   parameter int width = 34,
   parameter int depth = 256
) (
   input  wire logic                     clk,
   input  wire logic                     we,
   input  wire logic [$clog2(depth)-1:0] addr,
   input  wire logic [width-1:0]         d,
   output logic      [width-1:0]         q
);

   logic [width-1:0] mem [depth];          // No init, contents X until filled

   // Single port, read returns old data on a write cycle
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= d;
      end
      q <= mem[addr];                      // Registered read
   end

endmodule

`default_nettype wire

// File: design/ic_pkg.sv
`default_nettype none

`include "ic_mem_macros.svh"

package ic_pkg;

   //////////////////////////////////////////////////
   // Fetch side request
   //////////////////////////////////////////////////
   typedef struct packed {
      logic                             rd_en;    // Read strobe
      logic [`IC_NUM_WAYS-1:0]          wr_en;    // Fill, one bit per way
      logic [`IC_ADDR_W-1:3]            addr;     // 8-byte beat address
   } ic_req_t;

   //////////////////////////////////////////////////
   // Tag debug access
   //////////////////////////////////////////////////
   typedef struct packed {
      logic                             rd_en;
      logic                             wr_en;
      logic [`IC_NUM_WAYS-1:0]          way;      // One-hot
      logic [`IC_TAG_HIGH-1:`IC_TAG_LOW] index;
      logic [`IC_TAG_ENTRY_W-1:0]       wr_data;  // Written as is, parity included
   } ic_dbg_t;

   //////////////////////////////////////////////////
   // Tag lookup result, second cycle
   //////////////////////////////////////////////////
   typedef struct packed {
      logic [`IC_NUM_WAYS-1:0]          rd_hit;
      logic                             tag_perr;
   } ic_tag_rsp_t;

endpackage

`default_nettype wire

// File: design/ic_mem_macros.svh
`ifndef IC_MEM_MACROS_SVH
`define IC_MEM_MACROS_SVH

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////
`define IC_NUM_WAYS     4
`define IC_NUM_BANKS    4
`define IC_ADDR_W       32

// Fetch address split
`define IC_TAG_HIGH     12     // Tag is [31:12]
`define IC_TAG_LOW      6      // Tag index is [11:6]
`define IC_ROW_LOW      4      // Row index is [11:4]

//////////////////////////////////////////////////
// Array widths and depths
//////////////////////////////////////////////////
`define IC_WORD_W       32     // Instruction word per bank
`define IC_BANK_W       34     // Word plus 2 parity bits
`define IC_ROW_W        136    // Four banks
`define IC_FILL_W       68     // Two banks per fill beat
`define IC_PREMUX_W     128

`define IC_TAG_W        (`IC_ADDR_W - `IC_TAG_HIGH)
`define IC_TAG_ENTRY_W  21     // Parity on top of the tag
`define IC_TAG_DEPTH    (1 << (`IC_TAG_HIGH - `IC_TAG_LOW))
`define IC_DATA_DEPTH   (1 << (`IC_TAG_HIGH - `IC_ROW_LOW))

`endif
